// ==== regfile_config.svh ====
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// EAX through EDI
`define GPR_COUNT 8

// Register index width, log2 of GPR_COUNT
`define GPR_IDX_W 3

// Full dword width of one register
`define GPR_DATA_W 32

// Byte lanes per register
`define GPR_LANES 4

`endif

// ==== gpr_format_pkg.sv ====
`default_nettype none

`include "regfile_config.svh"

package gpr_format_pkg;

   // Access size codes, shared by read and write ports
   typedef enum logic [1:0] {
      size_8lo = 2'd0,
      size_8hi = 2'd1,
      size_16  = 2'd2,
      size_32  = 2'd3
   } access_size_e;

   // One register word seen as a dword or as its x86 sub-registers
   typedef union packed {
      logic [`GPR_DATA_W-1:0] dword;
      struct packed {
         logic [15:0] upper;
         logic [7:0]  hi;
         logic [7:0]  lo;
      } part;
   } gpr_word_u;

   // Bit 0 covers bits 7:0
   typedef logic [`GPR_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

// ==== gpr_index_pkg.sv ====
`default_nettype none

`include "regfile_config.svh"

package gpr_index_pkg;

   import gpr_format_pkg::*;

   typedef enum logic [`GPR_IDX_W-1:0] {
      idx_eax = 3'd0,
      idx_ecx = 3'd1,
      idx_edx = 3'd2,
      idx_ebx = 3'd3,
      idx_esp = 3'd4,
      idx_ebp = 3'd5,
      idx_esi = 3'd6,
      idx_edi = 3'd7
   } gpr_idx_e;

   // One lane mask per register, index 0 is EAX
   typedef lane_mask_t [`GPR_COUNT-1:0] gpr_lane_en_t;

endpackage

`default_nettype wire

// ==== gpr_write_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "regfile_config.svh"

module gpr_write_decode
   import gpr_format_pkg::*;
   import gpr_index_pkg::*;
(
   input  wire          wr_en,
   input  wire gpr_idx_e     wr_idx,
   input  wire access_size_e wr_size,
   output gpr_lane_en_t lane_en
);

   lane_mask_t size_mask;

   // Lanes touched by each access size
   always_comb begin
      case (wr_size)
         size_8lo: begin
            size_mask = 4'b0001;
         end
         size_8hi: begin
            size_mask = 4'b0010;
         end
         size_16: begin
            size_mask = 4'b0011;
         end
         size_32: begin
            size_mask = 4'b1111;
         end
         default: begin
            size_mask = 'x;
         end
      endcase
   end

   // Only the addressed register sees the mask
   // An unknown enable, index or size leaves the enables unknown
   always_comb begin
      for (int r = 0; r < `GPR_COUNT; r++) begin
         lane_en[r] = (wr_en && (wr_idx == r)) ? size_mask : '0;
      end
   end

endmodule

`default_nettype wire

// ==== gpr_storage.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "regfile_config.svh"

module gpr_storage
   import gpr_format_pkg::*;
(
   input  wire                               clk,
   input  wire                               arst_n,
   input  wire lane_mask_t [`GPR_COUNT-1:0]  lane_en0,
   input  wire lane_mask_t [`GPR_COUNT-1:0]  lane_en1,
   input  wire lane_mask_t [`GPR_COUNT-1:0]  lane_en2,
   input  wire access_size_e                 wr_size0,
   input  wire access_size_e                 wr_size1,
   input  wire access_size_e                 wr_size2,
   input  wire gpr_word_u                    wr_data0,
   input  wire gpr_word_u                    wr_data1,
   input  wire gpr_word_u                    wr_data2,
   output gpr_word_u                         gpr_regs [`GPR_COUNT]
);

   localparam int WR_PORTS = 3;
   localparam int LANE_W   = `GPR_DATA_W / `GPR_LANES;

   lane_mask_t [`GPR_COUNT-1:0] lane_en_p [WR_PORTS];
   access_size_e                wr_size_p [WR_PORTS];
   gpr_word_u                   wr_data_p [WR_PORTS];
   gpr_word_u                   wr_al     [WR_PORTS];
   gpr_word_u                   regs_nxt  [`GPR_COUNT];

   assign lane_en_p = '{lane_en0, lane_en1, lane_en2};
   assign wr_size_p = '{wr_size0, wr_size1, wr_size2};
   assign wr_data_p = '{wr_data0, wr_data1, wr_data2};

   // AH-style writes carry their byte in the low field of the data
   always_comb begin
      for (int p = 0; p < WR_PORTS; p++) begin
         wr_al[p] = wr_data_p[p];
         if (wr_size_p[p] == size_8hi) begin
            wr_al[p].part.hi = wr_data_p[p].part.lo;
         end
      end
   end

   // Walk ports from last to first so port 0 has the final say on a lane
   always_comb begin
      for (int r = 0; r < `GPR_COUNT; r++) begin
         regs_nxt[r] = gpr_regs[r];
         for (int l = 0; l < `GPR_LANES; l++) begin
            for (int p = WR_PORTS - 1; p >= 0; p--) begin
               if (lane_en_p[p][r][l]) begin
                  regs_nxt[r].dword[l*LANE_W +: LANE_W] =
                     wr_al[p].dword[l*LANE_W +: LANE_W];
               end
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gpr_regs <= '{default: '0};
      end else begin
         gpr_regs <= regs_nxt;
      end
   end

   // Decoders must hand over clean enables once out of reset
   a_lane_en_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      !$isunknown({lane_en0, lane_en1, lane_en2})
   );

   // A lane that may be enabled needs a known size to align its data
   property p_size_known(lane_mask_t [`GPR_COUNT-1:0] en, access_size_e size);
      @(posedge clk) disable iff (!arst_n)
      ((|en) !== 1'b0) |-> !$isunknown(size);
   endproperty

   a_size_known0: assert property (p_size_known(lane_en0, wr_size0));
   a_size_known1: assert property (p_size_known(lane_en1, wr_size1));
   a_size_known2: assert property (p_size_known(lane_en2, wr_size2));

endmodule

`default_nettype wire

// ==== gpr_read_port.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "regfile_config.svh"

module gpr_read_port
   import gpr_format_pkg::*;
   import gpr_index_pkg::*;
(
   input  wire gpr_word_u    gpr_regs [`GPR_COUNT],
   input  wire gpr_idx_e     rd_idx,
   input  wire access_size_e rd_size,
   output gpr_word_u         rd_data
);

   gpr_word_u sel_reg;

   assign sel_reg = gpr_regs[rd_idx];

   // Pull the addressed part down to bit 0 and clear everything above
   always_comb begin
      rd_data = '0;
      case (rd_size)
         size_8lo: begin
            rd_data.part.lo = sel_reg.part.lo;
         end
         size_8hi: begin
            // AH comes back in bits 7:0
            rd_data.part.lo = sel_reg.part.hi;
         end
         size_16: begin
            rd_data.part.hi = sel_reg.part.hi;
            rd_data.part.lo = sel_reg.part.lo;
         end
         size_32: begin
            rd_data = sel_reg;
         end
         default: begin
            rd_data = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== gpr_file.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "regfile_config.svh"

module gpr_file
   import gpr_format_pkg::*;
   import gpr_index_pkg::*;
(
   input  wire                    clk,
   input  wire                    arst_n,

   input  wire                    wr_en0,
   input  wire                    wr_en1,
   input  wire                    wr_en2,
   input  wire gpr_idx_e          wr_idx0,
   input  wire gpr_idx_e          wr_idx1,
   input  wire gpr_idx_e          wr_idx2,
   input  wire access_size_e      wr_size0,
   input  wire access_size_e      wr_size1,
   input  wire access_size_e      wr_size2,
   input  wire [`GPR_DATA_W-1:0]  wr_data0,
   input  wire [`GPR_DATA_W-1:0]  wr_data1,
   input  wire [`GPR_DATA_W-1:0]  wr_data2,

   input  wire gpr_idx_e          rd_idx0,
   input  wire gpr_idx_e          rd_idx1,
   input  wire gpr_idx_e          rd_idx2,
   input  wire gpr_idx_e          rd_idx3,
   input  wire access_size_e      rd_size0,
   input  wire access_size_e      rd_size1,
   input  wire access_size_e      rd_size2,
   input  wire access_size_e      rd_size3,
   output logic [`GPR_DATA_W-1:0] rd_data0,
   output logic [`GPR_DATA_W-1:0] rd_data1,
   output logic [`GPR_DATA_W-1:0] rd_data2,
   output logic [`GPR_DATA_W-1:0] rd_data3
);

   gpr_lane_en_t lane_en0;
   gpr_lane_en_t lane_en1;
   gpr_lane_en_t lane_en2;
   gpr_word_u    gpr_regs [`GPR_COUNT];

   // Write side decode, one per port
   gpr_write_decode dec0 (.wr_en(wr_en0), .wr_idx(wr_idx0), .wr_size(wr_size0),
                          .lane_en(lane_en0));
   gpr_write_decode dec1 (.wr_en(wr_en1), .wr_idx(wr_idx1), .wr_size(wr_size1),
                          .lane_en(lane_en1));
   gpr_write_decode dec2 (.wr_en(wr_en2), .wr_idx(wr_idx2), .wr_size(wr_size2),
                          .lane_en(lane_en2));

   gpr_storage stor0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .lane_en0 (lane_en0),
      .lane_en1 (lane_en1),
      .lane_en2 (lane_en2),
      .wr_size0 (wr_size0),
      .wr_size1 (wr_size1),
      .wr_size2 (wr_size2),
      .wr_data0 (wr_data0),
      .wr_data1 (wr_data1),
      .wr_data2 (wr_data2),
      .gpr_regs (gpr_regs)
   );

   // Four independent combinational read ports
   gpr_read_port rdp0 (.gpr_regs(gpr_regs), .rd_idx(rd_idx0), .rd_size(rd_size0),
                       .rd_data(rd_data0));
   gpr_read_port rdp1 (.gpr_regs(gpr_regs), .rd_idx(rd_idx1), .rd_size(rd_size1),
                       .rd_data(rd_data1));
   gpr_read_port rdp2 (.gpr_regs(gpr_regs), .rd_idx(rd_idx2), .rd_size(rd_size2),
                       .rd_data(rd_data2));
   gpr_read_port rdp3 (.gpr_regs(gpr_regs), .rd_idx(rd_idx3), .rd_size(rd_size3),
                       .rd_data(rd_data3));

endmodule

`default_nettype wire

// ==== tb_gpr_file.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "regfile_config.svh"

module tb_gpr_file
   import gpr_format_pkg::*;
   import gpr_index_pkg::*;
;

   // The tests run about 140 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic clk;
   logic arst_n;
   logic wr_en0, wr_en1, wr_en2;
   gpr_idx_e wr_idx0, wr_idx1, wr_idx2;
   access_size_e wr_size0, wr_size1, wr_size2;
   logic [`GPR_DATA_W-1:0] wr_data0, wr_data1, wr_data2;
   gpr_idx_e rd_idx0, rd_idx1, rd_idx2, rd_idx3;
   access_size_e rd_size0, rd_size1, rd_size2, rd_size3;
   logic [`GPR_DATA_W-1:0] rd_data0, rd_data1, rd_data2, rd_data3;

   logic [`GPR_DATA_W-1:0] model [`GPR_COUNT];
   logic [31:0] lcg_state;
   int errors;
   int checks;
   int tests_run;
   int cycle_count;

   gpr_file dut0 (
      .clk(clk), .arst_n(arst_n),
      .wr_en0(wr_en0), .wr_en1(wr_en1), .wr_en2(wr_en2),
      .wr_idx0(wr_idx0), .wr_idx1(wr_idx1), .wr_idx2(wr_idx2),
      .wr_size0(wr_size0), .wr_size1(wr_size1), .wr_size2(wr_size2),
      .wr_data0(wr_data0), .wr_data1(wr_data1), .wr_data2(wr_data2),
      .rd_idx0(rd_idx0), .rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
      .rd_size0(rd_size0), .rd_size1(rd_size1), .rd_size2(rd_size2), .rd_size3(rd_size3),
      .rd_data0(rd_data0), .rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // A write replaces exactly the byte lanes of its size
   function automatic logic [31:0] merge_write(logic [31:0] old, access_size_e size,
                                               logic [31:0] data);
      case (size)
         size_8lo: return {old[31:8], data[7:0]};
         size_8hi: return {old[31:16], data[7:0], old[7:0]};
         size_16:  return {old[31:16], data[15:0]};
         default:  return data;
      endcase
   endfunction

   function automatic logic [31:0] read_expect(logic [31:0] word, access_size_e size);
      case (size)
         size_8lo: return {24'd0, word[7:0]};
         size_8hi: return {24'd0, word[15:8]};
         size_16:  return {16'd0, word[15:0]};
         default:  return word;
      endcase
   endfunction

   task automatic set_write(input int port, input logic en, input gpr_idx_e idx,
                            input access_size_e size, input logic [31:0] data);
      case (port)
         0: begin
            wr_en0 = en;
            wr_idx0 = idx;
            wr_size0 = size;
            wr_data0 = data;
         end
         1: begin
            wr_en1 = en;
            wr_idx1 = idx;
            wr_size1 = size;
            wr_data1 = data;
         end
         default: begin
            wr_en2 = en;
            wr_idx2 = idx;
            wr_size2 = size;
            wr_data2 = data;
         end
      endcase
   endtask

   task automatic clear_writes();
      wr_en0 = 1'b0;
      wr_en1 = 1'b0;
      wr_en2 = 1'b0;
   endtask

   task automatic set_read(input int port, input gpr_idx_e idx, input access_size_e size);
      case (port)
         0: begin
            rd_idx0 = idx;
            rd_size0 = size;
         end
         1: begin
            rd_idx1 = idx;
            rd_size1 = size;
         end
         2: begin
            rd_idx2 = idx;
            rd_size2 = size;
         end
         default: begin
            rd_idx3 = idx;
            rd_size3 = size;
         end
      endcase
   endtask

   task automatic set_reads_all(input gpr_idx_e idx, input access_size_e size);
      for (int p = 0; p < 4; p++) begin
         set_read(p, idx, size);
      end
   endtask

   task automatic check_read_ports(input string test);
      logic [31:0] exp_v;
      logic [31:0] act_v [4];
      gpr_idx_e idx_v [4];
      access_size_e size_v [4];
      act_v = '{rd_data0, rd_data1, rd_data2, rd_data3};
      idx_v = '{rd_idx0, rd_idx1, rd_idx2, rd_idx3};
      size_v = '{rd_size0, rd_size1, rd_size2, rd_size3};
      for (int p = 0; p < 4; p++) begin
         exp_v = read_expect(model[idx_v[p]], size_v[p]);
         checks = checks + 1;
         if (act_v[p] !== exp_v) begin
            $display("Fail %s port %0d reg %0d size %0d expected %h actual %h",
                     test, p, idx_v[p], size_v[p], exp_v, act_v[p]);
            errors = errors + 1;
         end
      end
   endtask

   // Entered just after a falling edge with inputs driven; reads still see the old state
   task automatic step(input string test);
      #1;
      check_read_ports(test);
      @(posedge clk);
      // Port 0 goes last so it owns any lane it shares
      if (wr_en2) model[wr_idx2] = merge_write(model[wr_idx2], wr_size2, wr_data2);
      if (wr_en1) model[wr_idx1] = merge_write(model[wr_idx1], wr_size1, wr_data1);
      if (wr_en0) model[wr_idx0] = merge_write(model[wr_idx0], wr_size0, wr_data0);
      @(negedge clk);
   endtask

   task automatic report_test(input string test, input int errors_before);
      tests_run = tests_run + 1;
      $display("%s: %0d errors", test, errors - errors_before);
   endtask

   task automatic test_reset_zero();
      int e0;
      e0 = errors;
      for (int i = 0; i < `GPR_COUNT; i++) begin
         for (int s = 0; s < 4; s++) begin
            set_reads_all(gpr_idx_e'(i), access_size_e'(s));
            step("reset_zero");
         end
      end
      report_test("reset_zero", e0);
   endtask

   task automatic test_dword_write();
      int e0;
      e0 = errors;
      for (int i = 0; i < `GPR_COUNT; i++) begin
         set_write(0, 1'b1, gpr_idx_e'(i), size_32, next_rand());
         set_reads_all(gpr_idx_e'(i), size_32);
         step("dword_write");
         clear_writes();
         step("dword_write");
      end
      report_test("dword_write", e0);
   endtask

   task automatic test_partial_write();
      int e0;
      access_size_e sizes [3];
      e0 = errors;
      sizes = '{size_8lo, size_8hi, size_16};
      set_read(0, idx_ebx, size_32);
      set_read(1, idx_ebx, size_8lo);
      set_read(2, idx_ebx, size_8hi);
      set_read(3, idx_ebx, size_16);
      for (int k = 0; k < 3; k++) begin
         set_write(0, 1'b1, idx_ebx, size_32, 32'h1122_3344);
         step("partial_write");
         set_write(0, 1'b1, idx_ebx, sizes[k], 32'ha5c3_5a7e);
         step("partial_write");
         clear_writes();
         step("partial_write");
      end
      report_test("partial_write", e0);
   endtask

   task automatic test_sized_read();
      int e0;
      e0 = errors;
      for (int i = 0; i < `GPR_COUNT; i++) begin
         for (int s = 0; s < 3; s++) begin
            set_reads_all(gpr_idx_e'(i), access_size_e'(s));
            step("sized_read");
         end
      end
      report_test("sized_read", e0);
   endtask

   task automatic test_multi_port();
      int e0;
      e0 = errors;
      set_read(0, idx_ecx, size_32);
      set_read(1, idx_edx, size_32);
      set_read(2, idx_ebx, size_32);
      set_read(3, idx_ebp, size_32);
      // Different registers
      set_write(0, 1'b1, idx_ecx, size_32, next_rand());
      set_write(1, 1'b1, idx_edx, size_32, next_rand());
      set_write(2, 1'b1, idx_ebx, size_32, next_rand());
      step("multi_port");
      // Same register, disjoint lanes
      set_write(0, 1'b1, idx_ebp, size_8hi, 32'h0000_00c7);
      set_write(1, 1'b1, idx_ebp, size_8lo, 32'h0000_0019);
      set_write(2, 1'b0, idx_ebp, size_32, 32'hffff_ffff);
      step("multi_port");
      // Overlapping lanes
      set_read(0, idx_esi, size_32);
      set_write(0, 1'b1, idx_esi, size_8lo, 32'h0000_00aa);
      set_write(1, 1'b1, idx_esi, size_16, 32'h0000_bbbb);
      set_write(2, 1'b1, idx_esi, size_32, 32'hcccc_cccc);
      step("multi_port");
      set_write(0, 1'b0, idx_esi, size_32, 32'h0);
      set_write(1, 1'b1, idx_esi, size_8hi, 32'h0000_0055);
      set_write(2, 1'b1, idx_esi, size_32, 32'h6666_6666);
      step("multi_port");
      clear_writes();
      step("multi_port");
      report_test("multi_port", e0);
   endtask

   task automatic test_random_reads();
      int e0;
      logic [31:0] r;
      e0 = errors;
      for (int n = 0; n < 50; n++) begin
         for (int p = 0; p < 3; p++) begin
            r = next_rand();
            set_write(p, r[8], gpr_idx_e'(r[14:12]), access_size_e'(r[21:20]), next_rand());
         end
         for (int p = 0; p < 4; p++) begin
            r = next_rand();
            set_read(p, gpr_idx_e'(r[18:16]), access_size_e'(r[25:24]));
         end
         step("random_reads");
      end
      clear_writes();
      step("random_reads");
      report_test("random_reads", e0);
   endtask

   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      lcg_state = 32'h21df7091;
      errors = 0;
      checks = 0;
      tests_run = 0;
      cycle_count = 0;
      for (int i = 0; i < `GPR_COUNT; i++) begin
         model[i] = '0;
      end
      for (int p = 0; p < 3; p++) begin
         set_write(p, 1'b0, idx_eax, size_32, '0);
      end
      set_reads_all(idx_eax, size_32);
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      test_reset_zero();
      test_dword_write();
      test_partial_write();
      test_sized_read();
      test_multi_port();
      test_random_reads();

      $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
gpr_format_pkg.sv
gpr_index_pkg.sv
gpr_write_decode.sv
gpr_storage.sv
gpr_read_port.sv
gpr_file.sv
tb_gpr_file.sv
